//--- design/clk_timing_params.svh
////////////////////////////////////////////////////////////////////////////
// Fixed sizes and addresses of the board clock block
// Register map, APB widths, power-on hold and counter widths
////////////////////////////////////////////////////////////////////////////

`ifndef CLK_TIMING_PARAMS_SVH
`define CLK_TIMING_PARAMS_SVH

// APB bus widths
`define APB_ADDR_W       8
`define APB_DATA_W       32

// Register byte addresses
`define REG_CTRL_ADDR    8'h00
`define REG_STATUS_ADDR  8'h04
`define REG_TICK_ADDR    8'h08

// Cycles that ready waits once both locks are stable
`define POR_HOLD_CYCLES  64
`define HOLD_CNT_W       7

// Counter widths of the enable generator and the tick register
`define DIV21_CNT_W      3
`define DIV14_CNT_W      4
`define CPU_CNT_W        3
`define TICK_W           32

`endif

//--- design/clk_timing_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the board clock block
// CPU speed and sequencer enums, enable strobe and APB structs
////////////////////////////////////////////////////////////////////////////

`include "clk_timing_params.svh"

package clk_timing_pkg;

    // CPU divider applied to the 21.6 MHz strobe
    // Normal is 3.6 MHz, the reserved code runs at normal speed
    typedef enum logic [1:0] {
        SPEED_NORMAL = 2'd0,
        SPEED_TURBO2 = 2'd1,
        SPEED_TURBO3 = 2'd2,
        SPEED_RSVD   = 2'd3
    } cpu_speed_t;

    // Reset sequencer states
    typedef enum logic [1:0] {
        ST_WAIT_LOCK = 2'd0,
        ST_HOLD      = 2'd1,
        ST_READY     = 2'd2
    } seq_state_t;

    // Single-cycle clock enables in the CLK_BASE domain
    typedef struct packed {
        logic en_21m;
        logic en_14m;
        logic en_cpu;
    } clk_en_t;

    // APB request from the bus master
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // APB response back to the master
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

//--- design/reset_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Reset sequencer
// Two-flop synchronizers on both PLL lock flags and the FSM that
// releases sys_ready after the power-on hold
////////////////////////////////////////////////////////////////////////////

`include "clk_timing_params.svh"

module reset_sequencer (
    input  logic       CLK_BASE,
    input  logic       RESET_n,
    input  logic       base_lock,
    input  logic       tmds_lock,
    output logic [1:0] lock_sync,
    output logic       sys_ready
);
    import clk_timing_pkg::*;

    // The cycle spent entering ST_HOLD counts as the first hold cycle,
    // so the counter stops two short of the hold length
    localparam int unsigned HOLD_LAST = `POR_HOLD_CYCLES - 2;

    logic [1:0]             lock_meta;
    logic                   both_locked;
    seq_state_t             state;
    logic [`HOLD_CNT_W-1:0] hold_cnt;

    // Bit 0 carries the base PLL lock, bit 1 the TMDS PLL lock
    // The first stage may go metastable and is read by nothing else
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            lock_meta <= 2'b00;
            lock_sync <= 2'b00;
        end else begin
            lock_meta <= {tmds_lock, base_lock};
            lock_sync <= lock_meta;
        end
    end

    assign both_locked = &lock_sync;

    // Waits for both locks, holds for the power-on time, then stays ready
    // until a lock is lost; any loss sends it back to the start
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            state    <= ST_WAIT_LOCK;
            hold_cnt <= '0;
        end else begin
            case (state)
                ST_WAIT_LOCK: begin
                    hold_cnt <= '0;
                    if (both_locked) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // A lock glitch during the hold restarts the whole wait
                    if (!both_locked) begin
                        state <= ST_WAIT_LOCK;
                    end else if (hold_cnt == HOLD_LAST[`HOLD_CNT_W-1:0]) begin
                        state <= ST_READY;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                ST_READY: begin
                    if (!both_locked) begin
                        state <= ST_WAIT_LOCK;
                    end
                end
                default: state <= ST_WAIT_LOCK;
            endcase
        end
    end

    // Ready comes straight from the state register
    assign sys_ready = (state == ST_READY);

    // Ready may outlive a lock loss by one cycle at most
    a_ready_needs_lock: assert property (@(posedge CLK_BASE) disable iff (!RESET_n)
        sys_ready |-> $past(both_locked))
        else $error("sys_ready high after a lock was lost");

endmodule

//--- design/clock_enable_gen.sv
////////////////////////////////////////////////////////////////////////////
// Clock enable generator
// 21.6 MHz, 14.4 MHz and CPU enable strobes derived from CLK_BASE
////////////////////////////////////////////////////////////////////////////

`include "clk_timing_params.svh"

module clock_enable_gen (
    input  logic                       CLK_BASE,
    input  logic                       RESET_n,
    input  logic                       sys_ready,
    input  clk_timing_pkg::cpu_speed_t cpu_speed,
    output clk_timing_pkg::clk_en_t    clk_en
);
    import clk_timing_pkg::*;

    logic [`DIV21_CNT_W-1:0] cnt_21m;
    logic [`DIV14_CNT_W-1:0] cnt_14m;
    logic [`CPU_CNT_W-1:0]   cnt_cpu;
    logic [`CPU_CNT_W-1:0]   cpu_last;
    cpu_speed_t              speed_q;
    logic                    en_21m;
    logic                    en_14m;
    logic                    en_cpu;

    // Last en_21m count of one CPU period, which is the divider minus one
    function automatic logic [`CPU_CNT_W-1:0] cpu_last_of(input cpu_speed_t speed);
        case (speed)
            SPEED_TURBO2: cpu_last_of = 3'd2;
            SPEED_TURBO3: cpu_last_of = 3'd1;
            // Normal speed, and the reserved code falls in here as well
            default:      cpu_last_of = 3'd5;
        endcase
    endfunction

    // Mod-5 counter, 108 MHz / 5 = 21.6 MHz
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt_21m <= '0;
        end else if (!sys_ready || cnt_21m == 3'd4) begin
            cnt_21m <= '0;
        end else begin
            cnt_21m <= cnt_21m + 1'b1;
        end
    end

    // Mod-15 counter, two 14.4 MHz periods fit into 15 base cycles
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt_14m <= '0;
        end else if (!sys_ready || cnt_14m == 4'd14) begin
            cnt_14m <= '0;
        end else begin
            cnt_14m <= cnt_14m + 1'b1;
        end
    end

    assign en_21m = sys_ready && (cnt_21m == 3'd4);

    // The divided clock was high for counts 0..3 and 8..10, low elsewhere
    // Only its rising edges survive as strobes, 8 then 7 cycles apart
    always_comb begin
        case (cnt_14m)
            4'd0, 4'd8: en_14m = sys_ready;
            default:    en_14m = 1'b0;
        endcase
    end

    assign cpu_last = cpu_last_of(speed_q);
    assign en_cpu   = en_21m && (cnt_cpu == cpu_last);

    // CPU divider counts en_21m pulses with the speed latched at the boundary
    // A speed change from software therefore waits for the running period
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt_cpu <= '0;
            speed_q <= SPEED_NORMAL;
        end else if (!sys_ready || en_cpu) begin
            cnt_cpu <= '0;
            speed_q <= cpu_speed;
        end else if (en_21m) begin
            cnt_cpu <= cnt_cpu + 1'b1;
        end
    end

    assign clk_en.en_21m = en_21m;
    assign clk_en.en_14m = en_14m;
    assign clk_en.en_cpu = en_cpu;

    // Nothing may toggle before the clocks are declared stable
    a_quiet_until_ready: assert property (@(posedge CLK_BASE) disable iff (!RESET_n)
        !sys_ready |-> !(clk_en.en_21m || clk_en.en_14m))
        else $error("video enables active while not ready");

    // The CPU strobe is always a subset of the 21.6 MHz strobe
    a_cpu_on_21m: assert property (@(posedge CLK_BASE) disable iff (!RESET_n)
        clk_en.en_cpu |-> clk_en.en_21m)
        else $error("en_cpu without en_21m");

endmodule

//--- design/clock_ctrl_regs.sv
////////////////////////////////////////////////////////////////////////////
// Clock control registers on APB
// CTRL speed select, read-only STATUS and the CPU tick counter
////////////////////////////////////////////////////////////////////////////

`include "clk_timing_params.svh"

module clock_ctrl_regs (
    input  logic                       CLK_BASE,
    input  logic                       RESET_n,
    input  clk_timing_pkg::apb_req_t   apb_req,
    input  logic [1:0]                 lock_sync,
    input  logic                       sys_ready,
    input  clk_timing_pkg::clk_en_t    clk_en,
    output clk_timing_pkg::apb_rsp_t   apb_rsp,
    output clk_timing_pkg::cpu_speed_t cpu_speed
);
    import clk_timing_pkg::*;

    logic                   access;
    logic                   wr;
    logic                   rd;
    logic                   hit_ctrl;
    logic                   hit_status;
    logic                   hit_tick;
    logic                   unmapped;
    logic [1:0]             ctrl_speed;
    logic [`TICK_W-1:0]     tick_cnt;
    logic [`APB_DATA_W-1:0] rdata;

    // Access phase of an APB transfer, the setup phase does nothing here
    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;
    assign rd     = access && !apb_req.pwrite;

    // Full address compare, so aliases of the registers are unmapped
    assign hit_ctrl   = (apb_req.paddr == `REG_CTRL_ADDR);
    assign hit_status = (apb_req.paddr == `REG_STATUS_ADDR);
    assign hit_tick   = (apb_req.paddr == `REG_TICK_ADDR);
    assign unmapped   = !(hit_ctrl || hit_status || hit_tick);

    // CTRL keeps the raw code so software reads back what it wrote
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            ctrl_speed <= SPEED_NORMAL;
        end else if (wr && hit_ctrl) begin
            ctrl_speed <= apb_req.pwdata[1:0];
        end
    end

    // The reserved code drives the divider as normal speed
    assign cpu_speed = (ctrl_speed == SPEED_RSVD) ? SPEED_NORMAL : cpu_speed_t'(ctrl_speed);

    // CPU tick counter for software timekeeping
    // Any write clears it, and the clear beats a tick in the same cycle
    always_ff @(posedge CLK_BASE or negedge RESET_n) begin
        if (!RESET_n) begin
            tick_cnt <= '0;
        end else if (wr && hit_tick) begin
            tick_cnt <= '0;
        end else if (clk_en.en_cpu) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Read mux, only driven during the access phase of a read
    always_comb begin
        rdata = '0;
        if (rd) begin
            if (hit_ctrl) begin
                rdata[1:0] = ctrl_speed;
            end else if (hit_status) begin
                rdata[2:0] = {sys_ready, lock_sync};
            end else if (hit_tick) begin
                rdata = tick_cnt;
            end
        end
    end

    assign apb_rsp.prdata = rdata;

    // No wait states, every access completes in one access cycle
    assign apb_rsp.pready = 1'b1;

    // STATUS is read-only, so a write to it is an error like a bad address
    assign apb_rsp.pslverr = access && (unmapped || (apb_req.pwrite && hit_status));

    // The master must never be stalled in the access phase
    a_no_wait_states: assert property (@(posedge CLK_BASE) disable iff (!RESET_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else $error("APB access stalled");

endmodule

//--- design/board_clock_top.sv
////////////////////////////////////////////////////////////////////////////
// Board clock timing top level
// Connects the reset sequencer, the enable generator and the APB registers
////////////////////////////////////////////////////////////////////////////

module board_clock_top (
    input  logic                     CLK_BASE,
    input  logic                     RESET_n,
    input  logic                     base_lock,
    input  logic                     tmds_lock,
    input  clk_timing_pkg::apb_req_t apb_req,
    output clk_timing_pkg::apb_rsp_t apb_rsp,
    output clk_timing_pkg::clk_en_t  clk_en,
    output logic                     sys_ready
);
    import clk_timing_pkg::*;

    // Synchronized lock flags, bit 0 base PLL and bit 1 TMDS PLL
    logic [1:0] lock_sync;

    // Speed select from software, already mapped to a valid divider
    cpu_speed_t cpu_speed;

    // Lock synchronizers and the power-on hold before ready
    reset_sequencer u_reset_sequencer (
        .CLK_BASE  (CLK_BASE),
        .RESET_n   (RESET_n),
        .base_lock (base_lock),
        .tmds_lock (tmds_lock),
        .lock_sync (lock_sync),
        .sys_ready (sys_ready)
    );

    // Free-running strobes, started by sys_ready
    clock_enable_gen u_clock_enable_gen (
        .CLK_BASE  (CLK_BASE),
        .RESET_n   (RESET_n),
        .sys_ready (sys_ready),
        .cpu_speed (cpu_speed),
        .clk_en    (clk_en)
    );

    // Register block sees the strobes to count CPU ticks
    clock_ctrl_regs u_clock_ctrl_regs (
        .CLK_BASE  (CLK_BASE),
        .RESET_n   (RESET_n),
        .apb_req   (apb_req),
        .lock_sync (lock_sync),
        .sys_ready (sys_ready),
        .clk_en    (clk_en),
        .apb_rsp   (apb_rsp),
        .cpu_speed (cpu_speed)
    );

endmodule

//--- tb/clock_checker.sv
////////////////////////////////////////////////////////////////////////////
// Checker of the board clock block
// Cycle model of ready timing, strobes, CPU divider and APB registers
////////////////////////////////////////////////////////////////////////////

`include "clk_timing_params.svh"

module clock_checker (
    input  logic                     CLK_BASE,
    input  logic                     RESET_n,
    input  logic                     base_lock,
    input  logic                     tmds_lock,
    input  clk_timing_pkg::apb_req_t apb_req,
    input  clk_timing_pkg::apb_rsp_t apb_rsp,
    input  clk_timing_pkg::clk_en_t  clk_en,
    input  logic                     sys_ready,
    output int                       error_count,
    output int                       clear_hits
);
    import clk_timing_pkg::*;

    logic [1:0]  meta_m;
    logic [1:0]  sync_m;
    logic [1:0]  lock_prev;
    logic [1:0]  ctrl_m;
    logic [1:0]  wdata_prev;
    logic [31:0] tick_m;
    logic [31:0] rdata_m;
    logic        ready_m;
    logic        en21_m;
    logic        en14_m;
    logic        cpu_m;
    logic        wr_ctrl_prev;
    logic        wr_tick_prev;
    logic        cpu_seen_prev;
    logic        access;
    logic        mapped;
    int          run_m;
    int          phase_m;
    int          pulses_m;
    int          div_m;

    // Number of en_21m pulses in one CPU period for a CTRL code
    function automatic int divider_for(input logic [1:0] code);
        case (code)
            SPEED_TURBO2: divider_for = 3;
            SPEED_TURBO3: divider_for = 2;
            default:      divider_for = 6;
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    initial begin
        error_count = 0;
        clear_hits  = 0;
    end

    // Everything is sampled on the falling edge, half a cycle after the
    // DUT registers and the stimulus have settled
    always @(negedge CLK_BASE) begin
        if (!RESET_n) begin
            meta_m        = 2'b00;
            sync_m        = 2'b00;
            lock_prev     = 2'b00;
            ctrl_m        = SPEED_NORMAL;
            tick_m        = '0;
            ready_m       = 1'b0;
            cpu_m         = 1'b0;
            wr_ctrl_prev  = 1'b0;
            wr_tick_prev  = 1'b0;
            cpu_seen_prev = 1'b0;
            run_m         = 0;
            phase_m       = 0;
            pulses_m      = 0;
            div_m         = 6;
            compare_value("sys_ready in reset", 32'd0, sys_ready);
            compare_value("clk_en in reset", 32'd0, clk_en);
        end else begin
            // Speed is taken over while idle or at the end of a CPU period
            if (!ready_m || cpu_m) begin
                div_m = divider_for(ctrl_m);
            end
            if (wr_ctrl_prev) begin
                ctrl_m = wdata_prev;
            end
            // A clear wins over a tick in the same cycle
            if (wr_tick_prev) begin
                tick_m = '0;
                if (cpu_seen_prev) begin
                    clear_hits++;
                end
            end else if (cpu_seen_prev) begin
                tick_m = tick_m + 1;
            end
            phase_m = ready_m ? (phase_m + 1) % 15 : 0;
            // Ready follows POR_HOLD_CYCLES of stable synchronized locks, one cycle late
            ready_m = (run_m >= `POR_HOLD_CYCLES);
            sync_m  = meta_m;
            meta_m  = lock_prev;
            if (&sync_m) begin
                run_m = (run_m < 1000) ? run_m + 1 : run_m;
            end else begin
                run_m = 0;
            end
            en21_m = ready_m && (phase_m % 5 == 4);
            en14_m = ready_m && (phase_m == 0 || phase_m == 8);
            cpu_m  = 1'b0;
            if (!ready_m) begin
                pulses_m = 0;
            end else if (en21_m) begin
                if (pulses_m + 1 == div_m) begin
                    cpu_m    = 1'b1;
                    pulses_m = 0;
                end else begin
                    pulses_m++;
                end
            end
            compare_value("sys_ready", ready_m, sys_ready);
            compare_value("en_21m", en21_m, clk_en.en_21m);
            compare_value("en_14m", en14_m, clk_en.en_14m);
            compare_value("en_cpu", cpu_m, clk_en.en_cpu);

            access = apb_req.psel && apb_req.penable;
            mapped = (apb_req.paddr == `REG_CTRL_ADDR) || (apb_req.paddr == `REG_STATUS_ADDR)
                     || (apb_req.paddr == `REG_TICK_ADDR);
            compare_value("pslverr", access && (!mapped ||
                (apb_req.pwrite && apb_req.paddr == `REG_STATUS_ADDR)), apb_rsp.pslverr);
            if (access) begin
                compare_value("pready", 32'd1, apb_rsp.pready);
            end
            if (access && !apb_req.pwrite) begin
                rdata_m = '0;
                case (apb_req.paddr)
                    `REG_CTRL_ADDR:   rdata_m[1:0] = ctrl_m;
                    `REG_STATUS_ADDR: rdata_m[2:0] = {ready_m, sync_m};
                    `REG_TICK_ADDR:   rdata_m      = tick_m;
                    default:          rdata_m      = '0;
                endcase
                compare_value("prdata", rdata_m, apb_rsp.prdata);
            end

            // Inputs of this cycle act on the registers at the next edge
            lock_prev     = {tmds_lock, base_lock};
            wr_ctrl_prev  = access && apb_req.pwrite && (apb_req.paddr == `REG_CTRL_ADDR);
            wr_tick_prev  = access && apb_req.pwrite && (apb_req.paddr == `REG_TICK_ADDR);
            wdata_prev    = apb_req.pwdata[1:0];
            cpu_seen_prev = clk_en.en_cpu;
        end
    end

endmodule

//--- tb/tb_board_clock.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the board clock block
// Clock, reset, PLL lock sequences and random APB traffic around the DUT
////////////////////////////////////////////////////////////////////////////

`include "clk_timing_params.svh"

module tb_board_clock;
    import clk_timing_pkg::*;

    logic        CLK_BASE;
    logic        RESET_n;
    logic        base_lock;
    logic        tmds_lock;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    clk_en_t     clk_en;
    logic        sys_ready;
    int          error_count;
    int          clear_hits;
    int          clear_before;
    int          errors_before;
    int          tests_run;
    int          tests_failed;
    bit          aborted;

    board_clock_top uut (
        .CLK_BASE  (CLK_BASE),
        .RESET_n   (RESET_n),
        .base_lock (base_lock),
        .tmds_lock (tmds_lock),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .clk_en    (clk_en),
        .sys_ready (sys_ready)
    );

    // Watches the same pins and does all of the value checks
    clock_checker u_checker (
        .CLK_BASE    (CLK_BASE),
        .RESET_n     (RESET_n),
        .base_lock   (base_lock),
        .tmds_lock   (tmds_lock),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .clk_en      (clk_en),
        .sys_ready   (sys_ready),
        .error_count (error_count),
        .clear_hits  (clear_hits)
    );

    always #10 CLK_BASE = ~CLK_BASE;

    task automatic end_test(input string name, input bit failed_here);
        int new_errors;
        new_errors = error_count - errors_before;
        tests_run++;
        if (new_errors != 0 || failed_here || aborted) begin
            tests_failed++;
            $display("Test %s: FAIL with %0d mismatches", name, new_errors);
        end else begin
            $display("Test %s: PASS", name);
        end
        errors_before = error_count;
    endtask

    task automatic wait_for_ready(input logic level, input int limit);
        int n;
        n = 0;
        while (sys_ready !== level && n < limit) begin
            @(posedge CLK_BASE);
            n++;
        end
        if (sys_ready !== level) begin
            $display("Timeout: sys_ready did not become %0b within %0d cycles", level, limit);
            aborted = 1'b1;
        end
    endtask

    // Returns on the edge that ends a cycle with en_cpu high
    task automatic wait_for_cpu_tick(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge CLK_BASE);
            n++;
        end while (!clk_en.en_cpu && n < limit);
        if (!clk_en.en_cpu) begin
            $display("Timeout: no CPU enable within %0d cycles", limit);
            aborted = 1'b1;
        end
    endtask

    // One APB transfer with its setup phase on this edge and its access phase on the next
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data);
        int n;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge CLK_BASE);
        apb_req.penable <= 1'b1;
        n = 0;
        do begin
            @(posedge CLK_BASE);
            n++;
        end while (!apb_rsp.pready && n < 4);
        if (!apb_rsp.pready) begin
            $display("Timeout: APB access to %0h was never completed", addr);
            aborted = 1'b1;
        end
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    // Random read or write to a register or to the unmapped address 0x0C
    task automatic random_access();
        logic [7:0] addr;
        case ($urandom_range(3, 0))
            0:       addr = `REG_CTRL_ADDR;
            1:       addr = `REG_STATUS_ADDR;
            2:       addr = `REG_TICK_ADDR;
            default: addr = 8'h0C;
        endcase
        apb_transfer($urandom_range(1, 0), addr, $urandom);
    endtask

    initial begin
        void'($urandom(32'ha7e6));
        CLK_BASE      = 1'b0;
        RESET_n       = 1'b0;
        base_lock     = 1'b0;
        tmds_lock     = 1'b0;
        apb_req       = '0;
        tests_run     = 0;
        tests_failed  = 0;
        aborted       = 1'b0;
        repeat (16) @(posedge CLK_BASE);
        RESET_n <= 1'b1;
        errors_before = error_count;

        // Nothing may move before the PLLs report lock
        repeat (20) @(posedge CLK_BASE);
        end_test("reset_quiet", 1'b0);

        repeat ($urandom_range(30, 1)) @(posedge CLK_BASE);
        base_lock <= 1'b1;
        repeat ($urandom_range(30, 1)) @(posedge CLK_BASE);
        // Only the base lock has passed the synchronizer at this read
        apb_transfer(1'b0, `REG_STATUS_ADDR, 32'h0);
        tmds_lock <= 1'b1;
        repeat (4) @(posedge CLK_BASE);
        // Both locks are synchronized here while the power-on hold still runs
        apb_transfer(1'b0, `REG_STATUS_ADDR, 32'h0);
        wait_for_ready(1'b1, 200);
        end_test("lock_to_ready", 1'b0);

        repeat (150) @(posedge CLK_BASE);
        end_test("strobe_pattern", 1'b0);

        tmds_lock <= 1'b0;
        wait_for_ready(1'b0, 10);
        tmds_lock <= 1'b1;
        end_test("ready_lock_loss", 1'b0);

        // A short base lock glitch well inside the power-on hold
        repeat ($urandom_range(40, 8)) @(posedge CLK_BASE);
        base_lock <= 1'b0;
        repeat ($urandom_range(3, 1)) @(posedge CLK_BASE);
        base_lock <= 1'b1;
        wait_for_ready(1'b1, 200);
        end_test("hold_lock_loss", 1'b0);

        apb_transfer(1'b1, `REG_CTRL_ADDR, 32'h3);
        repeat (80) @(posedge CLK_BASE);
        repeat (12) begin
            apb_transfer(1'b1, `REG_CTRL_ADDR, $urandom);
            apb_transfer(1'b0, `REG_CTRL_ADDR, 32'h0);
            repeat ($urandom_range(60, 1)) @(posedge CLK_BASE);
        end
        end_test("cpu_speed", 1'b0);

        repeat (60) begin
            random_access();
            repeat ($urandom_range(3, 0)) @(posedge CLK_BASE);
        end
        end_test("register_access", 1'b0);

        // At divide by 2 en_cpu comes every 10 cycles, so a write started
        // 8 edges after a tick has its access phase on the next tick
        apb_transfer(1'b1, `REG_CTRL_ADDR, 32'h2);
        clear_before = clear_hits;
        wait_for_cpu_tick(100);
        repeat (3) begin
            wait_for_cpu_tick(40);
            repeat (8) @(posedge CLK_BASE);
            apb_transfer(1'b1, `REG_TICK_ADDR, $urandom);
            apb_transfer(1'b0, `REG_TICK_ADDR, 32'h0);
            repeat ($urandom_range(40, 5)) @(posedge CLK_BASE);
            apb_transfer(1'b0, `REG_TICK_ADDR, 32'h0);
        end
        if (clear_hits == clear_before) begin
            $display("TICK clear never landed on a CPU enable cycle");
        end
        end_test("tick_clear", clear_hits == clear_before);

        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0 && !aborted) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+design
design/clk_timing_pkg.sv
design/reset_sequencer.sv
design/clock_enable_gen.sv
design/clock_ctrl_regs.sv
design/board_clock_top.sv
tb/clock_checker.sv
tb/tb_board_clock.sv

//--- Bender.yml
package:
  name: board_clock

export_include_dirs:
  - design

sources:
  - files:
      - design/clk_timing_pkg.sv
      - design/reset_sequencer.sv
      - design/clock_enable_gen.sv
      - design/clock_ctrl_regs.sv
      - design/board_clock_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/clock_checker.sv
      - tb/tb_board_clock.sv
